// File: FetchUnit.f
+incdir+design
design/branchPkg.sv
design/fetchPkg.sv
design/BranchTargetBuffer.sv
design/ProgramCounter.sv
design/ParcelAligner.sv
design/FetchUnit.sv
tests/FetchUnit_properties.sv
tests/FetchUnit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = FetchUnit_tb
FILELIST  = FetchUnit.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJDIR)

// File: design/BranchTargetBuffer.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module BranchTargetBuffer (
    input  logic                 clk,
    input  logic                 rst,
    input  fetchPkg::ParcelPc    lookupPc,
    input  logic                 updValid,
    input  fetchPkg::FetchAddr   updPc,
    input  fetchPkg::FetchAddr   updDst,
    input  branchPkg::BranchKind updKind,
    input  logic                 updTaken,
    output logic                 branchFound,
    output logic                 branchTaken,
    output logic                 isJump,
    output fetchPkg::FetchAddr   branchSrc,
    output fetchPkg::FetchAddr   branchDst,
    output fetchPkg::BranchId    branchId,
    output logic                 multipleBranches
);
    import fetchPkg::*;
    import branchPkg::*;

    logic       entValid [`BTB_SETS][2];
    BtbTag      entTag   [`BTB_SETS][2];
    SlotIdx     entSlot  [`BTB_SETS][2];
    BranchKind  entKind  [`BTB_SETS][2];
    FetchAddr   entDst   [`BTB_SETS][2];
    PredCounter entCtr   [`BTB_SETS][2];

    logic [SetIdxW-1:0] lkSet;
    BtbTag              lkTag;
    SlotIdx             lkSlot;
    logic [1:0]         qual;
    logic               first;      // Way with the earliest qualifying slot
    logic               firstTaken;

    logic [SetIdxW-1:0] updSet;
    BtbTag              updTag;
    SlotIdx             updSlot;
    logic [1:0]         updHitVec;
    logic               updHit;
    logic               updWay;
    logic               allocWay;

    function automatic PredCounter bumpCtr(PredCounter c, logic taken);
        case (c)
            StrongNotTaken: return taken ? WeakNotTaken : StrongNotTaken;
            WeakNotTaken:   return taken ? WeakTaken : StrongNotTaken;
            WeakTaken:      return taken ? StrongTaken : WeakNotTaken;
            default:        return taken ? StrongTaken : WeakTaken;
        endcase
    endfunction

    assign lkSlot = lookupPc[1:0];
    assign lkSet  = lookupPc[SetIdxW+1:2];
    assign lkTag  = lookupPc[30:SetIdxW+2];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            qual[w] = entValid[lkSet][w] && entTag[lkSet][w] == lkTag
                && entSlot[lkSet][w] >= lkSlot;
        end
        if (&qual) begin
            first = entSlot[lkSet][1] < entSlot[lkSet][0];  // Tie goes to way 0
        end else begin
            first = qual[1];
        end
    end

    assign firstTaken = entKind[lkSet][first] == BrJump
        || entCtr[lkSet][first] inside {WeakTaken, StrongTaken};

    assign branchFound      = |qual;
    assign isJump           = branchFound && entKind[lkSet][first] == BrJump;
    assign branchTaken      = branchFound && firstTaken;
    assign branchSrc        = {lookupPc[30:2], entSlot[lkSet][first], 1'b0};
    assign branchDst        = entDst[lkSet][first];
    assign branchId         = BranchId'({lkSet, first});
    assign multipleBranches = &qual && !firstTaken;

    // Training side
    assign updSlot = updPc[2:1];
    assign updSet  = updPc[SetIdxW+2:3];
    assign updTag  = updPc[31:SetIdxW+3];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            updHitVec[w] = entValid[updSet][w] && entTag[updSet][w] == updTag
                && entSlot[updSet][w] == updSlot;
        end
    end

    assign updHit   = |updHitVec;
    assign updWay   = updHitVec[1];
    assign allocWay = entValid[updSet][0];   // Way 0 while free

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `BTB_SETS; s++) begin
                entValid[s][0] <= 1'b0;
                entValid[s][1] <= 1'b0;
            end
        end else if (updValid && !updHit && updTaken) begin
            entValid[updSet][allocWay] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updValid) begin
            if (updHit) begin
                entCtr[updSet][updWay]  <= bumpCtr(entCtr[updSet][updWay], updTaken);
                entDst[updSet][updWay]  <= updDst;
                entKind[updSet][updWay] <= updKind;
            end else if (updTaken) begin
                entTag[updSet][allocWay]  <= updTag;
                entSlot[updSet][allocWay] <= updSlot;
                entKind[updSet][allocWay] <= updKind;
                entDst[updSet][allocWay]  <= updDst;
                entCtr[updSet][allocWay]  <= WeakTaken;
            end
        end
    end

endmodule

// File: design/FetchUnit.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module FetchUnit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetchEn,
    input  logic                       redirect,
    input  fetchPkg::FetchAddr         redirectPc,
    input  logic                       updValid,
    input  fetchPkg::FetchAddr         updPc,
    input  fetchPkg::FetchAddr         updDst,
    input  branchPkg::BranchKind       updKind,
    input  logic                       updTaken,
    input  logic [`NUM_PARCELS*16-1:0] instrBlock,
    output fetchPkg::FetchAddr         pcAddr,
    output fetchPkg::Parcel            outInstr [`NUM_PARCELS],
    output fetchPkg::FetchAddr         outPc [`NUM_PARCELS],
    output fetchPkg::BranchId          outBranchId [`NUM_PARCELS],
    output logic [`NUM_PARCELS-1:0]    outPred,
    output logic [2:0]                 outCount,
    output logic                       outValid
);
    import fetchPkg::*;

    // BTB prediction for the current pc
    logic     branchFound;
    logic     branchTaken;
    logic     isJump;
    FetchAddr branchSrc;
    FetchAddr branchDst;
    BranchId  branchId;
    logic     multipleBranches;

    Parcel                   parcelInstr [`NUM_PARCELS];
    FetchAddr                parcelPc [`NUM_PARCELS];
    logic [`NUM_PARCELS-1:0] parcelValid;
    BranchId                 parcelBranchId [`NUM_PARCELS];
    logic [`NUM_PARCELS-1:0] parcelPred;

    BranchTargetBuffer btb (
        .clk(clk), .rst(rst),
        .lookupPc(pcAddr[31:1]),
        .updValid(updValid), .updPc(updPc), .updDst(updDst),
        .updKind(updKind), .updTaken(updTaken),
        .branchFound(branchFound), .branchTaken(branchTaken), .isJump(isJump),
        .branchSrc(branchSrc), .branchDst(branchDst), .branchId(branchId),
        .multipleBranches(multipleBranches)
    );

    ProgramCounter pcStage (
        .clk(clk), .rst(rst), .fetchEn(fetchEn),
        .redirect(redirect), .redirectPc(redirectPc), .instrBlock(instrBlock),
        .branchFound(branchFound), .branchTaken(branchTaken), .isJump(isJump),
        .branchSrc(branchSrc), .branchDst(branchDst), .branchId(branchId),
        .multipleBranches(multipleBranches),
        .pcRaw(pcAddr),
        .parcelInstr(parcelInstr), .parcelPc(parcelPc), .parcelValid(parcelValid),
        .parcelBranchId(parcelBranchId), .parcelPred(parcelPred)
    );

    ParcelAligner aligner (
        .clk(clk), .rst(rst), .fetchEn(fetchEn),
        .parcelInstr(parcelInstr), .parcelPc(parcelPc), .parcelValid(parcelValid),
        .parcelBranchId(parcelBranchId), .parcelPred(parcelPred),
        .outInstr(outInstr), .outPc(outPc), .outBranchId(outBranchId),
        .outPred(outPred), .outCount(outCount), .outValid(outValid)
    );

endmodule

// File: design/ParcelAligner.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module ParcelAligner (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetchEn,
    input  fetchPkg::Parcel         parcelInstr [`NUM_PARCELS],
    input  fetchPkg::FetchAddr      parcelPc [`NUM_PARCELS],
    input  logic [`NUM_PARCELS-1:0] parcelValid,
    input  fetchPkg::BranchId       parcelBranchId [`NUM_PARCELS],
    input  logic [`NUM_PARCELS-1:0] parcelPred,
    output fetchPkg::Parcel         outInstr [`NUM_PARCELS],
    output fetchPkg::FetchAddr      outPc [`NUM_PARCELS],
    output fetchPkg::BranchId       outBranchId [`NUM_PARCELS],
    output logic [`NUM_PARCELS-1:0] outPred,
    output logic [2:0]              outCount,
    output logic                    outValid
);
    import fetchPkg::*;

    Parcel                   packInstr [`NUM_PARCELS];
    FetchAddr                packPc [`NUM_PARCELS];
    BranchId                 packId [`NUM_PARCELS];
    logic [`NUM_PARCELS-1:0] packPred;
    logic [2:0]              cnt;

    // Order preserving compaction, cnt doubles as the write slot
    always_comb begin
        cnt = 3'd0;
        for (int i = 0; i < `NUM_PARCELS; i++) begin
            packInstr[i] = '0;
            packPc[i]    = '0;
            packId[i]    = '0;
            packPred[i]  = 1'b0;
        end
        for (int i = 0; i < `NUM_PARCELS; i++) begin
            if (parcelValid[i]) begin
                packInstr[SlotIdx'(cnt)] = parcelInstr[i];
                packPc[SlotIdx'(cnt)]    = parcelPc[i];
                packId[SlotIdx'(cnt)]    = parcelBranchId[i];
                packPred[SlotIdx'(cnt)]  = parcelPred[i];
                cnt = cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outCount <= 3'd0;
            outValid <= 1'b0;
        end else if (fetchEn) begin
            outCount <= cnt;
            outValid <= cnt != 3'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchEn) begin
            outInstr    <= packInstr;
            outPc       <= packPc;
            outBranchId <= packId;
            outPred     <= packPred;
        end
    end

endmodule

// File: design/ProgramCounter.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module ProgramCounter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetchEn,
    input  logic                     redirect,
    input  fetchPkg::FetchAddr       redirectPc,
    input  logic [`NUM_PARCELS*16-1:0] instrBlock,
    input  logic                     branchFound,
    input  logic                     branchTaken,
    input  logic                     isJump,
    input  fetchPkg::FetchAddr       branchSrc,
    input  fetchPkg::FetchAddr       branchDst,
    input  fetchPkg::BranchId        branchId,
    input  logic                     multipleBranches,
    output fetchPkg::FetchAddr       pcRaw,
    output fetchPkg::Parcel          parcelInstr [`NUM_PARCELS],
    output fetchPkg::FetchAddr       parcelPc [`NUM_PARCELS],
    output logic [`NUM_PARCELS-1:0]  parcelValid,
    output fetchPkg::BranchId        parcelBranchId [`NUM_PARCELS],
    output logic [`NUM_PARCELS-1:0]  parcelPred
);
    import fetchPkg::*;

    ParcelPc pc;

    // Metadata of the block whose data arrives next cycle
    ParcelPc                 pcLast;
    logic [`NUM_PARCELS-1:0] maskLast;
    logic                    brValidLast;
    SlotIdx                  brSlotLast;
    BranchId                 brIdLast;
    logic                    brPredLast;

    SlotIdx                  brSlot;
    logic                    predTaken;
    ParcelPc                 seqPc;
    ParcelPc                 nextPc;
    logic [`NUM_PARCELS-1:0] cutMask;
    logic [`NUM_PARCELS-1:0] nextMask;

    assign pcRaw     = {pc, 1'b0};
    assign brSlot    = branchSrc[2:1];
    assign predTaken = branchFound && (isJump || branchTaken);
    assign seqPc     = {pc[30:2] + 29'd1, 2'b00};

    always_comb begin
        for (int i = 0; i < `NUM_PARCELS; i++) begin
            cutMask[i] = i <= brSlot;   // Keep up to the branch slot
        end
        if (predTaken) begin
            nextPc   = branchDst[31:1];
            nextMask = cutMask;
        end else if (branchFound && multipleBranches) begin
            // Second branch later in the block, restart just after this one
            nextPc   = branchSrc[31:1] + 31'd1;
            nextMask = cutMask;
        end else begin
            nextPc   = seqPc;
            nextMask = '1;
        end
    end

    // Redirect flushes both blocks in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            maskLast    <= '0;
            brValidLast <= 1'b0;
            brPredLast  <= 1'b0;
            parcelValid <= '0;
            parcelPred  <= '0;
        end else if (fetchEn) begin
            if (redirect) begin
                pc          <= redirectPc[31:1];
                maskLast    <= '0;
                brValidLast <= 1'b0;
                parcelValid <= '0;
                parcelPred  <= '0;
            end else begin
                pc          <= nextPc;
                maskLast    <= nextMask;
                brValidLast <= branchFound;
                brPredLast  <= predTaken;
                for (int i = 0; i < `NUM_PARCELS; i++) begin
                    parcelValid[i] <= maskLast[i] && i >= pcLast[1:0];
                    parcelPred[i]  <= brValidLast && brPredLast && brSlotLast == i;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchEn && !redirect) begin
            pcLast     <= pc;
            brSlotLast <= brSlot;
            brIdLast   <= branchId;
            for (int i = 0; i < `NUM_PARCELS; i++) begin
                parcelInstr[i] <= instrBlock[16*i +: 16];
                parcelPc[i]    <= {pcLast[30:2], SlotIdx'(i), 1'b0};
                // Only the branch slot carries an ID
                parcelBranchId[i] <= (brValidLast && brSlotLast == i) ? brIdLast : '0;
            end
        end
    end

endmodule

// File: design/branchPkg.sv
`include "fetch_cfg.svh"

package branchPkg;

    typedef enum logic {
        BrCond,     // Conditional branch
        BrJump      // Unconditional jump
    } BranchKind;

    // Two-bit saturating counter, upper half predicts taken
    typedef enum logic [1:0] {
        StrongNotTaken = 2'b00,
        WeakNotTaken   = 2'b01,
        WeakTaken      = 2'b10,
        StrongTaken    = 2'b11
    } PredCounter;

    localparam int SetIdxW = $clog2(`BTB_SETS);

    // Address bits above set index and block offset
    localparam int TagW = 32 - SetIdxW - 3;

    typedef logic [TagW-1:0] BtbTag;

endpackage

// File: design/fetchPkg.sv
`include "fetch_cfg.svh"

package fetchPkg;

    // Byte address
    typedef logic [31:0] FetchAddr;

    // Halfword address, byte address without bit 0
    typedef logic [30:0] ParcelPc;

    typedef logic [$clog2(`NUM_PARCELS)-1:0] SlotIdx;

    typedef logic [15:0] Parcel;

    typedef logic [`BRANCH_ID_W-1:0] BranchId;

endpackage

// File: design/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// 16-bit parcels per 8-byte fetch block
`define NUM_PARCELS 4

// BTB sets, two ways per set
`define BTB_SETS 8

`define BRANCH_ID_W 8

`endif

// File: tests/FetchUnit_properties.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module FetchUnit_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    fetchEn,
    input logic                    redirect,
    input fetchPkg::FetchAddr      redirectPc,
    input logic [`NUM_PARCELS-1:0] parcelValid,
    input logic [`NUM_PARCELS-1:0] parcelPred
);
    logic [`NUM_PARCELS-1:0] lowBit;

    assign lowBit = parcelValid & (~parcelValid + 1'b1);  // Lowest valid slot

    // The pc drops bit 0, so a loaded target has to be even
    pcEven: assert property (@(posedge clk) disable iff (rst)
        fetchEn && redirect |-> !redirectPc[0])
        else $error("redirect target is not halfword aligned");

    // One run from the start slot up to the cut, no holes
    validRun: assert property (@(posedge clk) disable iff (rst)
        ((parcelValid + lowBit) & parcelValid) == '0)
        else $error("parcel valid bits are not contiguous");

    onePred: assert property (@(posedge clk) disable iff (rst) $onehot0(parcelPred))
        else $error("more than one parcel predicted taken");

    resetClear: assert property (@(posedge clk) rst |=> parcelValid == '0)
        else $error("parcels valid right after reset");

endmodule

bind ProgramCounter FetchUnit_properties props (
    .clk(clk), .rst(rst), .fetchEn(fetchEn),
    .redirect(redirect), .redirectPc(redirectPc),
    .parcelValid(parcelValid), .parcelPred(parcelPred)
);

// File: tests/FetchUnit_tb.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module FetchUnit_tb;
    import fetchPkg::*;
    import branchPkg::*;

    localparam int MaxRows = 40;

    logic clk, rst, fetchEn, redirect, updValid, updTaken, outValid;
    FetchAddr redirectPc, updPc, updDst, pcAddr;
    BranchKind updKind;
    logic [`NUM_PARCELS*16-1:0] instrBlock;
    Parcel outInstr [`NUM_PARCELS];
    FetchAddr outPc [`NUM_PARCELS];
    BranchId outBranchId [`NUM_PARCELS];
    logic [`NUM_PARCELS-1:0] outPred;
    logic [2:0] outCount;

    // Stimulus and expected results, one row per clock
    logic tEn [MaxRows], tRedir [MaxRows], tUpd [MaxRows], tTaken [MaxRows];
    FetchAddr tRedirPc [MaxRows], tUpdPc [MaxRows], tUpdDst [MaxRows], tPc [MaxRows];
    BranchKind tKind [MaxRows];
    logic [2:0] tCnt [MaxRows];
    logic [3:0] tPred [MaxRows];
    int tIdSlot [MaxRows];
    BranchId tId [MaxRows];

    int nRows, errors, checks, pend, cur, i, lastRow;
    int unsigned seedVal;
    FetchAddr prevPc, s1, s2, outAddr;

    FetchUnit dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic Parcel patternAt(FetchAddr a);
        return a[16:1] ^ 16'hA5A5;   // Halfword address low bits
    endfunction

    // Instruction memory, synchronous read
    always @(posedge clk) begin
        if (fetchEn) begin
            for (int s = 0; s < `NUM_PARCELS; s++) begin
                instrBlock[16*s +: 16] <= patternAt({pcAddr[31:3], 3'b000} + FetchAddr'(2*s));
            end
        end
    end

    task automatic addRow(logic en, logic rd, FetchAddr rPc, logic uv, FetchAddr uPc,
                          FetchAddr uDst, BranchKind k, logic tk, FetchAddr ePc,
                          logic [2:0] eCnt, logic [3:0] ePred, int idSlot, BranchId id);
        tEn[nRows] = en;
        tRedir[nRows] = rd;
        tRedirPc[nRows] = rPc;
        tUpd[nRows] = uv;
        tUpdPc[nRows] = uPc;
        tUpdDst[nRows] = uDst;
        tKind[nRows] = k;
        tTaken[nRows] = tk;
        tPc[nRows] = ePc;
        tCnt[nRows] = eCnt;
        tPred[nRows] = ePred;
        tIdSlot[nRows] = idSlot;
        tId[nRows] = id;
        nRows++;
    endtask

    task automatic seqRow(FetchAddr ePc, logic [2:0] eCnt);
        addRow(1, 0, 0, 0, 0, 0, BrCond, 0, ePc, eCnt, 4'b0, -1, 0);
    endtask

    task automatic buildTable();
        seqRow(32'h008, 0);
        seqRow(32'h010, 0);
        seqRow(32'h018, 4);
        seqRow(32'h020, 4);
        seqRow(32'h028, 4);
        seqRow(32'h030, 4);
        addRow(1, 1, 32'h102, 0, 0, 0, BrCond, 0, 32'h102, 4, 4'b0, -1, 0);  // Odd slot
        seqRow(32'h108, 0);
        seqRow(32'h110, 0);
        seqRow(32'h118, 3);
        seqRow(32'h120, 4);
        addRow(1, 0, 0, 1, 32'h134, 32'h200, BrJump, 1, 32'h128, 4, 4'b0, -1, 0);
        seqRow(32'h130, 4);
        seqRow(32'h200, 4);
        seqRow(32'h208, 4);
        addRow(1, 0, 0, 0, 0, 0, BrCond, 0, 32'h210, 3, 4'b0100, 2, 8'd12);
        seqRow(32'h218, 4);
        addRow(1, 0, 0, 1, 32'h302, 32'h380, BrCond, 1, 32'h220, 4, 4'b0, -1, 0);
        addRow(1, 0, 0, 1, 32'h302, 32'h380, BrCond, 0, 32'h228, 4, 4'b0, -1, 0);
        addRow(1, 0, 0, 1, 32'h302, 32'h380, BrCond, 0, 32'h230, 4, 4'b0, -1, 0);
        addRow(1, 0, 0, 1, 32'h306, 32'h400, BrCond, 1, 32'h238, 4, 4'b0, -1, 0);
        addRow(1, 1, 32'h300, 0, 0, 0, BrCond, 0, 32'h300, 4, 4'b0, -1, 0);
        seqRow(32'h304, 0);
        seqRow(32'h400, 0);
        seqRow(32'h408, 2);
        addRow(1, 0, 0, 0, 0, 0, BrCond, 0, 32'h410, 2, 4'b0010, 1, 8'd1);
        seqRow(32'h418, 4);
        seqRow(32'h420, 4);
        addRow(0, 0, 0, 0, 0, 0, BrCond, 0, 32'h420, 4, 4'b0, -1, 0);
        seqRow(32'h428, 4);
        seqRow(32'h430, 4);
    endtask

    task automatic checkAddr(string name, FetchAddr got, FetchAddr exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkParcel(string name, Parcel got, Parcel exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(string name, logic [2:0] got, logic [2:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkId(string name, BranchId got, BranchId exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkPred(string name, logic [3:0] got, logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic driveRow(int k);
        fetchEn <= tEn[k];
        redirect <= tRedir[k];
        redirectPc <= tRedirPc[k];
        updValid <= tUpd[k];
        updPc <= tUpdPc[k];
        updDst <= tUpdDst[k];
        updKind <= tKind[k];
        updTaken <= tTaken[k];
    endtask

    task automatic driveStall();
        fetchEn <= 1'b0;
        redirect <= 1'b0;
        updValid <= 1'b0;
    endtask

    // Checks the effect of what was sampled at the last rising edge
    task automatic evaluate(int k);
        FetchAddr a;
        if (k >= 0) begin
            lastRow = k;
            if (tEn[k]) begin   // Two enabled edges from fetch to output
                outAddr = s2;
                s2 = s1;
                s1 = prevPc;
                prevPc = tPc[k];
            end
        end
        if (lastRow >= 0) begin
            // A stall cycle expects the state of the last row again
            checkAddr("pcAddr", pcAddr, tPc[lastRow]);
            checkCount("outCount", outCount, tCnt[lastRow]);
            checkFlag("outValid", outValid, tCnt[lastRow] != 3'd0);
            checkPred("outPred", outPred, tPred[lastRow]);
            for (int j = 0; j < `NUM_PARCELS; j++) begin
                a = outAddr + FetchAddr'(2*j);
                if (j < int'(tCnt[lastRow])) begin
                    checkAddr($sformatf("outPc[%0d]", j), outPc[j], a);
                    checkParcel($sformatf("outInstr[%0d]", j), outInstr[j], patternAt(a));
                end else begin
                    checkAddr($sformatf("outPc[%0d]", j), outPc[j], FetchAddr'(0));
                    checkParcel($sformatf("outInstr[%0d]", j), outInstr[j], Parcel'(0));
                end
                checkId($sformatf("outBranchId[%0d]", j), outBranchId[j],
                        (j == tIdSlot[lastRow]) ? tId[lastRow] : BranchId'(0));
            end
        end
    endtask

    initial begin
        seedVal = $urandom(32'h8ec1_f6e8);
        rst = 1'b1;
        fetchEn = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        updValid = 1'b0;
        updPc = '0;
        updDst = '0;
        updKind = BrCond;
        updTaken = 1'b0;
        instrBlock = '0;
        nRows = 0;
        errors = 0;
        checks = 0;
        buildTable();
        prevPc = '0;
        s1 = '0;
        s2 = '0;
        outAddr = '0;
        lastRow = -1;
        pend = -2;
        i = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (i <= nRows) begin
            @(posedge clk);
            if (i > 0 && i < nRows && $urandom % 4 == 0) begin
                driveStall();   // Random stall cycle
                cur = -1;
            end else if (i < nRows) begin
                driveRow(i);
                cur = i;
                i++;
            end else begin
                driveStall();
                cur = -1;
                i++;
            end
            @(negedge clk);
            evaluate(pend);
            pend = cur;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #1;
        #(nRows * 40 + 1000);
        $display("watchdog expired before the stimulus table completed");
        $display("=== FAIL ===");
        $finish;
    end

endmodule
